/* source/id_pkg.sv */
// decode stage package: widths, major opcodes and control field encodings
`default_nettype none

package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;
  localparam int REG_COUNT   = 32;

  // rv64i major opcodes, subset only
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [REG_ADDR_WD-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1,
    SRC1_PC
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR  // link value pc+4
  } src2_sel_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_COND,
    BR_JAL,
    BR_JALR
  } br_kind_e;

  // encoded as funct3 of the branch
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_func_e;

endpackage

`default_nettype wire

/* source/id_pipe_reg.sv */
// decode input register: valid bit, instruction and pc with valid/allowin handshake
`default_nettype none
`timescale 1ns/1ps

module id_pipe_reg import id_pkg::*; (
  input  logic  i_clk,
  input  logic  i_reset,
  input  logic  i_fs_to_ds_valid,
  input  inst_t i_fs_inst,
  input  xlen_t i_fs_pc,
  input  logic  i_es_allowin,
  input  logic  i_load_stall,
  output logic  o_ds_allowin,
  output logic  o_ds_valid,
  output logic  o_ds_to_es_valid,
  output inst_t o_inst,
  output xlen_t o_pc
);

  logic  ds_valid_q;
  logic  ds_ready_go;
  inst_t inst_q;
  xlen_t pc_q;

  assign ds_ready_go      = ~i_load_stall;  // only a load-use hazard holds us
  assign o_ds_allowin     = ~ds_valid_q | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid_q & ds_ready_go;
  assign o_ds_valid       = ds_valid_q;
  assign o_inst           = inst_q;
  assign o_pc             = pc_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid_q <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      inst_q <= i_fs_inst;
      pc_q   <= i_fs_pc;
    end
  end

  // a stalled or back-pressured instruction must not be overwritten
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_ds_valid && !o_ds_allowin) |=> ($stable(o_inst) && $stable(o_pc)));

endmodule

`default_nettype wire

/* source/id_decoder.sv */
// instruction decoder: register indices, immediate and control fields for the rv64i subset
`default_nettype none
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  inst_t     i_inst,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output xlen_t     o_imm,
  output alu_op_e   o_alu_op,
  output src1_sel_e o_src1_sel,
  output src2_sel_e o_src2_sel,
  output logic      o_gpr_wen,
  output logic      o_mem_ren,  // also marks a load
  output logic      o_mem_wen,
  output logic      o_invalid,
  output br_kind_e  o_br_kind,
  output br_func_e  o_br_func
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1_f;
  reg_addr_t  rs2_f;
  reg_addr_t  rd_f;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rd_f   = i_inst[11:7];
  assign rs1_f  = i_inst[19:15];
  assign rs2_f  = i_inst[24:20];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    // unused register fields stay 0 so they never match a bypass or stall
    o_rs1      = '0;
    o_rs2      = '0;
    o_rd       = '0;
    o_imm      = '0;
    o_alu_op   = ALU_ADD;
    o_src1_sel = SRC1_RS1;
    o_src2_sel = SRC2_RS2;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_invalid  = 1'b0;
    o_br_kind  = BR_NONE;
    o_br_func  = BR_EQ;

    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: o_alu_op = ALU_AND;
          {7'b0000000, 3'b110}: o_alu_op = ALU_OR;
          {7'b0000000, 3'b100}: o_alu_op = ALU_XOR;
          {7'b0000000, 3'b010}: o_alu_op = ALU_SLT;
          default:              o_invalid = 1'b1;
        endcase
        if (!o_invalid) begin
          o_rs1     = rs1_f;
          o_rs2     = rs2_f;
          o_rd      = rd_f;
          o_gpr_wen = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin  // addi
          o_rs1      = rs1_f;
          o_rd       = rd_f;
          o_imm      = imm_i;
          o_src2_sel = SRC2_IMM;
          o_gpr_wen  = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_LUI: begin
        o_rd       = rd_f;  // rs1 left at x0 gives 0 + imm
        o_imm      = imm_u;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b011) begin  // ld
          o_rs1      = rs1_f;
          o_rd       = rd_f;
          o_imm      = imm_i;
          o_src2_sel = SRC2_IMM;
          o_gpr_wen  = 1'b1;
          o_mem_ren  = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b011) begin  // sd
          o_rs1      = rs1_f;
          o_rs2      = rs2_f;
          o_imm      = imm_s;
          o_src2_sel = SRC2_IMM;
          o_mem_wen  = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          o_invalid = 1'b1;
        end else begin
          o_rs1     = rs1_f;
          o_rs2     = rs2_f;
          o_imm     = imm_b;
          o_br_kind = BR_COND;
          o_br_func = br_func_e'(funct3);
        end
      end
      OPC_JAL: begin
        o_rd       = rd_f;
        o_imm      = imm_j;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_br_kind  = BR_JAL;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_rs1      = rs1_f;
          o_rd       = rd_f;
          o_imm      = imm_i;
          o_src1_sel = SRC1_PC;
          o_src2_sel = SRC2_FOUR;
          o_gpr_wen  = 1'b1;
          o_br_kind  = BR_JALR;
        end else begin
          o_invalid = 1'b1;
        end
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* source/id_gpr_file.sv */
// general register file: 32 x 64, two async read ports, one write port, x0 hardwired
`default_nettype none
`timescale 1ns/1ps

module id_gpr_file import id_pkg::*; (
  input  logic      i_clk,
  input  reg_addr_t i_raddr1,
  output xlen_t     o_rdata1,
  input  reg_addr_t i_raddr2,
  output xlen_t     o_rdata2,
  input  logic      i_wen,
  input  reg_addr_t i_waddr,
  input  xlen_t     i_wdata
);

  xlen_t regs [REG_COUNT];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_x0_zero: assert property (@(posedge i_clk)
    ((i_raddr1 == '0) |-> (o_rdata1 == '0)) and ((i_raddr2 == '0) |-> (o_rdata2 == '0)));

endmodule

`default_nettype wire

/* source/id_hazard_unit.sv */
// operand bypass from es/ms/ws and load-use stall detection
`default_nettype none
`timescale 1ns/1ps

module id_hazard_unit import id_pkg::*; (
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  input  xlen_t     i_rf_rdata1,
  input  xlen_t     i_rf_rdata2,
  input  reg_addr_t i_es_fwd_rd,
  input  xlen_t     i_es_fwd_data,
  input  reg_addr_t i_ms_fwd_rd,
  input  xlen_t     i_ms_fwd_data,
  input  reg_addr_t i_ws_fwd_rd,
  input  xlen_t     i_ws_fwd_data,
  input  logic      i_es_load_sel,
  input  logic      i_ds_valid,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output logic      o_load_stall
);

  // youngest producer wins and rd 0 never forwards
  function automatic xlen_t pick_operand(input reg_addr_t rs, input xlen_t rf_data);
    xlen_t val;
    if (i_es_fwd_rd != '0 && rs == i_es_fwd_rd) begin
      val = i_es_fwd_data;
    end else if (i_ms_fwd_rd != '0 && rs == i_ms_fwd_rd) begin
      val = i_ms_fwd_data;
    end else if (i_ws_fwd_rd != '0 && rs == i_ws_fwd_rd) begin
      val = i_ws_fwd_data;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  always_comb begin
    o_rs1_data = pick_operand(i_rs1, i_rf_rdata1);
    o_rs2_data = pick_operand(i_rs2, i_rf_rdata2);
  end

  // load data only exists from mem onward
  assign o_load_stall = i_ds_valid && i_es_load_sel && (i_es_fwd_rd != '0) &&
                        ((i_es_fwd_rd == i_rs1) || (i_es_fwd_rd == i_rs2));

endmodule

`default_nettype wire

/* source/id_branch_unit.sv */
// branch unit resolving taken, target and stall toward fetch for branches and jumps
`default_nettype none
`timescale 1ns/1ps

module id_branch_unit import id_pkg::*; (
  input  logic     i_ds_valid,
  input  logic     i_load_stall,
  input  br_kind_e i_br_kind,
  input  br_func_e i_br_func,
  input  xlen_t    i_rs1_data,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_pc,
  input  xlen_t    i_imm,
  output logic     o_br_taken,
  output xlen_t    o_br_target,
  output logic     o_br_stall
);

  logic  cond_true;
  xlen_t jalr_sum;

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond_true = (i_rs1_data == i_rs2_data);
      BR_NE:   cond_true = (i_rs1_data != i_rs2_data);
      BR_LT:   cond_true = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   cond_true = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:  cond_true = (i_rs1_data < i_rs2_data);
      BR_GEU:  cond_true = (i_rs1_data >= i_rs2_data);
      default: cond_true = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_taken = i_ds_valid && (((i_br_kind == BR_COND) && cond_true) ||
                                     (i_br_kind == BR_JAL) || (i_br_kind == BR_JALR));
  assign o_br_target = (i_br_kind == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                              : i_pc + i_imm;
  // operands not final yet so fetch has to wait
  assign o_br_stall = o_br_taken && i_load_stall;

endmodule

`default_nettype wire

/* source/id_stage.sv */
// decode stage top: pipeline register, decoder, register file, bypass and branch resolution
`default_nettype none
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,
  // fetch side
  input  logic      i_fs_to_ds_valid,
  input  inst_t     i_fs_inst,
  input  xlen_t     i_fs_pc,
  output logic      o_ds_allowin,
  // execute side
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output xlen_t     o_es_rs1_data,
  output xlen_t     o_es_rs2_data,
  output xlen_t     o_es_imm,
  output xlen_t     o_es_pc,
  output alu_op_e   o_es_alu_op,
  output src1_sel_e o_es_src1_sel,
  output src2_sel_e o_es_src2_sel,
  output reg_addr_t o_es_rd,
  output logic      o_es_gpr_wen,
  output logic      o_es_mem_ren,
  output logic      o_es_mem_wen,
  output logic      o_es_invalid,
  // writeback
  input  logic      i_ws_rf_wen,
  input  reg_addr_t i_ws_rf_waddr,
  input  xlen_t     i_ws_rf_wdata,
  // bypass
  input  reg_addr_t i_es_fwd_rd,
  input  xlen_t     i_es_fwd_data,
  input  reg_addr_t i_ms_fwd_rd,
  input  xlen_t     i_ms_fwd_data,
  input  reg_addr_t i_ws_fwd_rd,
  input  xlen_t     i_ws_fwd_data,
  input  logic      i_es_load_sel,
  // to fetch
  output logic      o_br_taken,
  output xlen_t     o_br_target,
  output logic      o_br_stall
);

  logic      ds_valid;
  logic      load_stall;
  inst_t     ds_inst;
  xlen_t     ds_pc;
  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     imm;
  xlen_t     rf_rdata1;
  xlen_t     rf_rdata2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  br_kind_e  br_kind;
  br_func_e  br_func;

  assign o_es_pc       = ds_pc;
  assign o_es_imm      = imm;
  assign o_es_rs1_data = rs1_data;
  assign o_es_rs2_data = rs2_data;

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc)
  );

  id_decoder u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_es_rd),
    .o_imm      (imm),
    .o_alu_op   (o_es_alu_op),
    .o_src1_sel (o_es_src1_sel),
    .o_src2_sel (o_es_src2_sel),
    .o_gpr_wen  (o_es_gpr_wen),
    .o_mem_ren  (o_es_mem_ren),
    .o_mem_wen  (o_es_mem_wen),
    .o_invalid  (o_es_invalid),
    .o_br_kind  (br_kind),
    .o_br_func  (br_func)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_ws_rf_wen),
    .i_waddr  (i_ws_rf_waddr),
    .i_wdata  (i_ws_rf_wdata)
  );

  id_hazard_unit u_hazard_unit (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_fwd_rd   (i_es_fwd_rd),
    .i_es_fwd_data (i_es_fwd_data),
    .i_ms_fwd_rd   (i_ms_fwd_rd),
    .i_ms_fwd_data (i_ms_fwd_data),
    .i_ws_fwd_rd   (i_ws_fwd_rd),
    .i_ws_fwd_data (i_ws_fwd_data),
    .i_es_load_sel (i_es_load_sel),
    .i_ds_valid    (ds_valid),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch_unit (
    .i_ds_valid   (ds_valid),
    .i_load_stall (load_stall),
    .i_br_kind    (br_kind),
    .i_br_func    (br_func),
    .i_rs1_data   (rs1_data),  // bypassed operands
    .i_rs2_data   (rs2_data),
    .i_pc         (ds_pc),
    .i_imm        (imm),
    .o_br_taken   (o_br_taken),
    .o_br_target  (o_br_target),
    .o_br_stall   (o_br_stall)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// testbench clock and reset source: 8 ns clock, reset held for the first two edges
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);

  localparam int HALF_PERIOD = 4;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (2) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb/tb_id_stage.sv */
// decode stage testbench replaying the cases file against the DUT and checking its outputs
`default_nettype none
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int    TIMEOUT_CYCLES = 20;
  localparam int    SEED           = 47504;
  localparam string CASES_FILE     = "tb/id_stage_cases.txt";
  // characters seen by the record parser
  localparam int    CH_HASH = 35;
  localparam int    CH_NL   = 10;
  localparam int    CH_CR   = 13;
  localparam int    CH_SP   = 32;
  localparam int    CH_TAB  = 9;
  localparam int    CH_W    = 87;
  localparam int    CH_D    = 68;

  logic      i_clk;
  logic      i_reset;
  logic      i_fs_to_ds_valid;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc;
  logic      o_ds_allowin;
  logic      i_es_allowin;
  logic      o_ds_to_es_valid;
  xlen_t     o_es_rs1_data;
  xlen_t     o_es_rs2_data;
  xlen_t     o_es_imm;
  xlen_t     o_es_pc;
  alu_op_e   o_es_alu_op;
  src1_sel_e o_es_src1_sel;
  src2_sel_e o_es_src2_sel;
  reg_addr_t o_es_rd;
  logic      o_es_gpr_wen;
  logic      o_es_mem_ren;
  logic      o_es_mem_wen;
  logic      o_es_invalid;
  logic      i_ws_rf_wen;
  reg_addr_t i_ws_rf_waddr;
  xlen_t     i_ws_rf_wdata;
  reg_addr_t i_es_fwd_rd;
  xlen_t     i_es_fwd_data;
  reg_addr_t i_ms_fwd_rd;
  xlen_t     i_ms_fwd_data;
  reg_addr_t i_ws_fwd_rd;
  xlen_t     i_ws_fwd_data;
  logic      i_es_load_sel;
  logic      o_br_taken;
  xlen_t     o_br_target;
  logic      o_br_stall;

  logic [63:0] f [24];  // fields of the current D record

  tb_clock_gen u_clock_gen (.o_clk(i_clk), .o_reset(i_reset));

  id_stage dut (.*);

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_src1_sel(input string name, input src1_sel_e got, input src1_sel_e exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_src2_sel(input string name, input src2_sel_e got, input src2_sel_e exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic wait_allowin();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_allowin) begin
      n++;
      if (n > TIMEOUT_CYCLES) report_fail("timeout while waiting for o_ds_allowin");
      @(negedge i_clk);
    end
  endtask

  task automatic wait_es_valid();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_to_es_valid) begin
      n++;
      if (n > TIMEOUT_CYCLES) report_fail("timeout while waiting for o_ds_to_es_valid");
      @(negedge i_clk);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input xlen_t data);
    @(posedge i_clk);
    i_ws_rf_wen   <= 1'b1;
    i_ws_rf_waddr <= addr;
    i_ws_rf_wdata <= data;
    @(posedge i_clk);
    i_ws_rf_wen   <= 1'b0;
  endtask

  // random background so unwritten registers hold no zeros
  task automatic fill_regs();
    xlen_t data;
    void'($urandom(SEED));
    for (int r = 1; r < REG_COUNT; r++) begin
      data = {$urandom(), $urandom()} ^ xlen_t'(r);
      write_reg(r[4:0], data);
    end
  endtask

  task automatic check_fields();
    check_xlen("o_es_rs1_data", o_es_rs1_data, f[10]);
    check_xlen("o_es_rs2_data", o_es_rs2_data, f[11]);
    check_xlen("o_es_imm", o_es_imm, f[12]);
    check_xlen("o_es_pc", o_es_pc, f[1]);
    check_alu_op("o_es_alu_op", o_es_alu_op, alu_op_e'(f[13][2:0]));
    check_src1_sel("o_es_src1_sel", o_es_src1_sel, src1_sel_e'(f[14][0]));
    check_src2_sel("o_es_src2_sel", o_es_src2_sel, src2_sel_e'(f[15][1:0]));
    check_reg_addr("o_es_rd", o_es_rd, f[16][4:0]);
    check_bit("o_es_gpr_wen", o_es_gpr_wen, f[17][0]);
    check_bit("o_es_mem_ren", o_es_mem_ren, f[18][0]);
    check_bit("o_es_mem_wen", o_es_mem_wen, f[19][0]);
    check_bit("o_es_invalid", o_es_invalid, f[20][0]);
    check_bit("o_br_taken", o_br_taken, f[21][0]);
    if (f[21][0]) check_xlen("o_br_target", o_br_target, f[22]);
  endtask

  task automatic run_decode();
    int load_cycles;
    int bp_cycles;
    load_cycles = f[8][31:0];
    bp_cycles   = f[9][31:0];
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= f[0][31:0];
    i_fs_pc          <= f[1];
    wait_allowin();
    @(posedge i_clk);  // instruction taken here
    i_fs_to_ds_valid <= 1'b0;
    i_es_fwd_rd      <= f[2][4:0];
    i_es_fwd_data    <= f[3];
    i_ms_fwd_rd      <= f[4][4:0];
    i_ms_fwd_data    <= f[5];
    i_ws_fwd_rd      <= f[6][4:0];
    i_ws_fwd_data    <= f[7];
    i_es_load_sel    <= (load_cycles != 0);
    i_es_allowin     <= (bp_cycles == 0);
    for (int i = 0; i < load_cycles; i++) begin
      @(negedge i_clk);
      check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
      check_bit("o_ds_allowin", o_ds_allowin, 1'b0);
      check_bit("o_br_taken", o_br_taken, f[21][0]);
      check_bit("o_br_stall", o_br_stall, f[23][0]);
    end
    if (load_cycles != 0) begin
      @(posedge i_clk);
      i_es_load_sel <= 1'b0;
    end
    for (int i = 0; i < bp_cycles; i++) begin
      @(negedge i_clk);
      check_bit("o_ds_allowin", o_ds_allowin, 1'b0);
      check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
      check_fields();
    end
    if (bp_cycles != 0) begin
      @(posedge i_clk);
      i_es_allowin <= 1'b1;
    end
    wait_es_valid();
    check_fields();
    check_bit("o_ds_allowin", o_ds_allowin, 1'b1);
    check_bit("o_br_stall", o_br_stall, 1'b0);
  endtask

  initial begin
    int fd;
    int c;
    int cnt;
    int n;
    int n_cases;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_ws_rf_wen      = 1'b0;
    i_ws_rf_waddr    = '0;
    i_ws_rf_wdata    = '0;
    i_es_fwd_rd      = '0;
    i_es_fwd_data    = '0;
    i_ms_fwd_rd      = '0;
    i_ms_fwd_data    = '0;
    i_ws_fwd_rd      = '0;
    i_ws_fwd_data    = '0;
    i_es_load_sel    = 1'b0;
    n_cases          = 0;

    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) report_fail("could not open the cases file");

    n = 0;
    @(negedge i_clk);
    while (i_reset) begin
      n++;
      if (n > TIMEOUT_CYCLES) report_fail("timeout while waiting for reset to end");
      @(negedge i_clk);
    end
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_bit("o_br_taken", o_br_taken, 1'b0);
    check_bit("o_ds_allowin", o_ds_allowin, 1'b1);

    fill_regs();

    c = $fgetc(fd);
    while (c != -1) begin
      if (c == CH_HASH) begin
        while (c != CH_NL && c != -1) c = $fgetc(fd);
      end else if (c == CH_W) begin
        cnt = $fscanf(fd, " %h %h", f[0], f[1]);
        if (cnt != 2) report_fail("malformed register write record in cases file");
        write_reg(f[0][4:0], f[1]);
        n_cases++;
      end else if (c == CH_D) begin
        cnt = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        cnt += $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                       f[22], f[23]);
        if (cnt != 24) report_fail("malformed decode record in cases file");
        run_decode();
        n_cases++;
      end else if (c != CH_NL && c != CH_CR && c != CH_SP && c != CH_TAB) begin
        report_fail("unknown record type in cases file");
      end
      if (c != -1) c = $fgetc(fd);
    end
    $fclose(fd);
    if (n_cases == 0) report_fail("cases file held no records");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/id_stage_cases.txt */
# W addr data
# D inst pc es_rd es_data ms_rd ms_data ws_rd ws_data load bp rs1 rs2 imm alu src1 src2 rd gpr_wen mem_ren mem_wen invalid taken target stall
W 01 a
W 02 3
W 03 ffffffffffffffff
W 05 100
W 00 55
D 00208333 1000 0 0 0 0 0 0 0 0 a 3 0 0 0 0 06 1 0 0 0 0 1000 0
D 402083b3 1004 0 0 0 0 0 0 0 0 a 3 0 1 0 0 07 1 0 0 0 0 1004 0
D 00200433 1008 0 0 0 0 0 0 0 0 0 3 0 0 0 0 08 1 0 0 0 0 1008 0
D ffb08493 100c 0 0 0 0 0 0 0 0 a 0 fffffffffffffffb 0 0 1 09 1 0 0 0 0 1007 0
D 80000537 1010 0 0 0 0 0 0 0 0 0 0 ffffffff80000000 0 0 1 0a 1 0 0 0 0 ffffffff80001010 0
D 0102b583 1014 0 0 0 0 0 0 0 0 100 0 10 0 0 1 0b 1 1 0 0 0 1024 0
D fe22bc23 1018 0 0 0 0 0 0 0 0 100 3 fffffffffffffff8 0 0 1 00 0 0 1 0 0 1010 0
D 00208333 1020 1 111 1 222 2 333 0 0 111 333 0 0 0 0 06 1 0 0 0 0 1020 0
D 00200433 1024 0 999 2 222 2 333 0 0 0 222 0 0 0 0 08 1 0 0 0 0 1024 0
D 00208333 1028 2 444 0 0 0 0 3 0 a 444 0 0 0 0 06 1 0 0 0 0 1028 0
D 00208863 2000 0 0 0 0 0 0 0 0 a 3 10 0 0 0 00 0 0 0 0 0 2010 0
D 00209863 2004 0 0 0 0 0 0 0 0 a 3 10 0 0 0 00 0 0 0 0 1 2014 0
D 0011c863 2008 0 0 0 0 0 0 0 0 ffffffffffffffff a 10 0 0 0 00 0 0 0 0 1 2018 0
D 0011d863 200c 0 0 0 0 0 0 0 0 ffffffffffffffff a 10 0 0 0 00 0 0 0 0 0 201c 0
D 0011e863 2010 0 0 0 0 0 0 0 0 ffffffffffffffff a 10 0 0 0 00 0 0 0 0 0 2020 0
D 0011f863 2014 0 0 0 0 0 0 0 0 ffffffffffffffff a 10 0 0 0 00 0 0 0 0 1 2024 0
D fe1ff66f 3000 0 0 0 0 0 0 0 0 0 0 ffffffffffffffe0 0 1 2 0c 1 0 0 0 1 2fe0 0
D 005286e7 3004 0 0 0 0 0 0 0 0 100 0 5 0 1 2 0d 1 0 0 0 1 104 0
D 00209863 4000 1 7 0 0 0 0 2 0 7 3 10 0 0 0 00 0 0 0 0 1 4010 1
D ffb08493 5000 0 0 0 0 0 0 0 4 a 0 fffffffffffffffb 0 0 1 09 1 0 0 0 0 4ffb 0
D 0000007f 6000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 1 0 6000 0

/* id_stage.f */
source/id_pkg.sv
source/id_pipe_reg.sv
source/id_decoder.sv
source/id_gpr_file.sv
source/id_hazard_unit.sv
source/id_branch_unit.sv
source/id_stage.sv
tb/tb_clock_gen.sv
tb/tb_id_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = tb_id_stage
FILELIST  = id_stage.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
